// ==== Makefile ====
# Verilator build and run of the bus front end testbench

VERILATOR ?= verilator
TOP ?= tb_pc_bus_frontend
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bus_decode.sv ====
module bus_decode #(
	parameter int cpu_clk_div = 2
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  bus_pkg::addr_t                cpu_a,
	input  logic                          cpu_bhe_n,
	input  logic                          cpu_s0_n,
	input  logic                          cpu_s1_n,
	input  logic                          cpu_mio,
	input  logic                          cpu_inta_n,
	input  bus_pkg::word_t                cpu_wdata,
	output logic                          cpu_clk_n,
	output logic                          phase_tick,
	output bus_pkg::cycle_e               cycle,
	output logic                          mem_rd_req,
	output logic                          mem_wr_req,
	output map_pkg::region_e              mem_region,
	output bus_pkg::addr_t                mem_addr,
	output logic                          mem_bhe_n,
	output bus_pkg::word_t                mem_wdata,
	input  logic                          mem_ack,
	output logic                          mem_busy,
	output logic                          io_start,
	output logic                          io_write,
	output map_pkg::dev_e                 io_dev,
	output logic [bus_pkg::port_w-1:0]    io_port,
	output logic                          cpu_a0,
	output logic                          cpu_bhe_n_q,
	output bus_pkg::word_t                io_wword
);

localparam int cnt_w = (cpu_clk_div > 1) ? $clog2(cpu_clk_div) : 1;

logic [cnt_w-1:0] div_cnt;
logic div_end;
logic [3:0] cmd;
logic [bus_pkg::port_w-1:0] port;
logic bios_area;
logic vram_area;
bus_pkg::cycle_e cycle_d;
map_pkg::region_e region_d;
map_pkg::dev_e dev_d;
// Status seen at the previous tick
logic [1:0] stat_q;
logic t1;
logic t2;

//////////////////////////////////////////////////////////////////////
// CPU clock
//////////////////////////////////////////////////////////////////////

assign div_end = div_cnt == cnt_w'(cpu_clk_div - 1);

always_ff @(posedge clk or negedge reset_n)
begin
	if (!reset_n)
	begin
		div_cnt <= '0;
		cpu_clk_n <= 1'b0;
		phase_tick <= 1'b0;
	end
	else
	begin
		div_cnt <= div_end ? '0 : div_cnt + 1'b1;
		if (div_end)
			cpu_clk_n <= ~cpu_clk_n;
		// High in the first clk with cpu_clk_n low
		phase_tick <= div_end && cpu_clk_n;
	end
end

//////////////////////////////////////////////////////////////////////
// Status and address decode
//////////////////////////////////////////////////////////////////////

assign cmd = {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n};
assign port = cpu_a[bus_pkg::port_w-1:0];

always_comb
begin
	if (cmd == bus_pkg::stat_inta)
		cycle_d = bus_pkg::inta;
	else
		case (cmd[2:0])
			bus_pkg::stat_mem_read:  cycle_d = bus_pkg::mem_read;
			bus_pkg::stat_mem_write: cycle_d = bus_pkg::mem_write;
			bus_pkg::stat_io_read:   cycle_d = bus_pkg::io_read;
			bus_pkg::stat_io_write:  cycle_d = bus_pkg::io_write;
			default:                 cycle_d = bus_pkg::idle;
		endcase
end

// BIOS sits at the top of the first MB and of the 16 MB space
assign bios_area = map_pkg::mem_hit(cpu_a, map_pkg::bios_lo_base, map_pkg::bios_cmp_w) ||
	map_pkg::mem_hit(cpu_a, map_pkg::bios_hi_base, map_pkg::bios_cmp_w);
assign vram_area = map_pkg::mem_hit(cpu_a, map_pkg::vram_base, map_pkg::vram_cmp_w);

// BIOS only shadows RAM on reads, writes fall through
always_comb
begin
	if (bios_area && cycle_d == bus_pkg::mem_read)
		region_d = map_pkg::bios;
	else if (vram_area)
		region_d = map_pkg::vram;
	else
		region_d = map_pkg::ram;
end

always_comb
begin
	if (map_pkg::io_hit(port, map_pkg::spi_base, map_pkg::spi_cmp_w))
		dev_d = map_pkg::spi;
	else if (map_pkg::io_hit(port, map_pkg::pit_base, map_pkg::pit_cmp_w))
		dev_d = map_pkg::pit;
	else if (map_pkg::io_hit(port, map_pkg::pic_base, map_pkg::pic_cmp_w))
		dev_d = map_pkg::pic;
	else if (map_pkg::io_hit(port, map_pkg::vga_lo_base, map_pkg::vga_cmp_w) ||
		map_pkg::io_hit(port, map_pkg::vga_hi_base, map_pkg::vga_cmp_w) ||
		map_pkg::io_hit(port, map_pkg::vga_alt_base, map_pkg::vga_alt_cmp_w))
		dev_d = map_pkg::vga;
	// Reading the debug port hits nothing
	else if (map_pkg::io_hit(port, map_pkg::dbg_base, map_pkg::dbg_cmp_w) &&
		cycle_d == bus_pkg::io_write)
		dev_d = map_pkg::dbg;
	else if (map_pkg::io_hit(port, map_pkg::ps2_base, map_pkg::ps2_cmp_w))
		dev_d = map_pkg::ps2;
	else if (map_pkg::io_hit(port, map_pkg::opl_base, map_pkg::opl_cmp_w))
		dev_d = map_pkg::opl;
	else if (map_pkg::io_hit(port, map_pkg::com1_base, map_pkg::com1_cmp_w))
		dev_d = map_pkg::com1;
	else
		dev_d = map_pkg::none;
end

//////////////////////////////////////////////////////////////////////
// T1 capture and T2 launch
//////////////////////////////////////////////////////////////////////

// T1 while status is active, T2 on the tick after
assign t1 = phase_tick && (!cpu_s1_n || !cpu_s0_n);
assign t2 = phase_tick && !t1 && stat_q != 2'b11;

always_ff @(posedge clk or negedge reset_n)
begin
	if (!reset_n)
	begin
		stat_q <= 2'b11;
		cycle <= bus_pkg::idle;
		mem_rd_req <= 1'b0;
		mem_wr_req <= 1'b0;
		io_start <= 1'b0;
	end
	else
	begin
		if (phase_tick)
			stat_q <= {cpu_s1_n, cpu_s0_n};
		if (t1)
			cycle <= cycle_d;
		if (t2 && cycle == bus_pkg::mem_read)
			mem_rd_req <= ~mem_rd_req;
		if (t2 && cycle == bus_pkg::mem_write)
			mem_wr_req <= ~mem_wr_req;
		// One clk pulse into the byte bridge
		io_start <= t2 && (cycle == bus_pkg::io_read || cycle == bus_pkg::io_write);
	end
end

always_ff @(posedge clk)
begin
	if (t1)
	begin
		mem_addr <= cpu_a;
		mem_bhe_n <= cpu_bhe_n;
		mem_region <= region_d;
		io_dev <= dev_d;
	end
	// Write data is valid from T2
	if (t2)
		mem_wdata <= cpu_wdata;
end

// One request toggles per cycle, so the pair's parity tracks the ack
assign mem_busy = (mem_rd_req ^ mem_wr_req) != mem_ack;

// I/O side shares the captured address and data
assign io_write = cycle == bus_pkg::io_write;
assign io_port = mem_addr[bus_pkg::port_w-1:0];
assign cpu_a0 = mem_addr[0];
assign cpu_bhe_n_q = mem_bhe_n;
assign io_wword = mem_wdata;

endmodule

// ==== bus_pkg.sv ====
package bus_pkg;

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

localparam int addr_w = 24;
localparam int data_w = 16;
// I/O ports decode on the low address bits only
localparam int port_w = 12;

// CPU address
typedef logic [addr_w-1:0] addr_t;
// CPU data word
typedef logic [data_w-1:0] word_t;
// Datum of an 8-bit I/O device
typedef logic [7:0] byte_t;

//////////////////////////////////////////////////////////////////////
// Status codes
//////////////////////////////////////////////////////////////////////

// Compared against {mio, s1_n, s0_n}
localparam logic [2:0] stat_mem_read  = 3'b101;
localparam logic [2:0] stat_mem_write = 3'b110;
localparam logic [2:0] stat_io_read   = 3'b001;
localparam logic [2:0] stat_io_write  = 3'b010;

// Interrupt acknowledge needs inta_n too, {inta_n, mio, s1_n, s0_n}
localparam logic [3:0] stat_inta = 4'b0000;

// Bus cycle type, halt and passive states fold into idle
typedef enum logic [2:0] {
	idle,
	mem_read,
	mem_write,
	io_read,
	io_write,
	inta
} cycle_e;

endpackage

// ==== files.f ====
bus_pkg.sv
map_pkg.sv
bus_decode.sv
io_bridge.sv
read_return.sv
pc_bus_frontend.sv
tb_pc_bus_frontend.sv

// ==== io_bridge.sv ====
module io_bridge (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          io_start,
	input  logic                          io_write,
	input  map_pkg::dev_e                 io_dev,
	input  logic [bus_pkg::port_w-1:0]    io_port,
	input  logic                          cpu_a0,
	input  logic                          cpu_bhe_n_q,
	input  bus_pkg::word_t                io_wword,
	output logic                          io_req,
	output logic                          io_req_write,
	output map_pkg::dev_e                 io_dev_sel,
	output logic [bus_pkg::port_w-1:0]    io_addr,
	output bus_pkg::byte_t                io_wdata,
	input  logic                          io_ack,
	input  bus_pkg::byte_t                io_rdata,
	output logic                          io_busy,
	output bus_pkg::word_t                io_result
);

typedef enum logic [1:0] {
	idle,
	low_byte,
	high_byte
} state_e;

state_e state;
// High byte still owed after the low one
logic hi_pending;
// Write data for the second byte cycle
bus_pkg::byte_t hi_byte;
logic acked;
logic start_ok;

// Nothing outstanding once the device has answered
assign acked = io_req == io_ack;
assign start_ok = state == idle && io_start;

// Busy from the start pulse on, so the ready logic never sees a gap
assign io_busy = io_start || state != idle;

//////////////////////////////////////////////////////////////////////
// Byte sequencer
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge reset_n)
begin
	if (!reset_n)
	begin
		state <= idle;
		io_req <= 1'b0;
		hi_pending <= 1'b0;
	end
	else
	begin
		case (state)
			idle:
			begin
				// Unmapped port completes here without any request
				if (io_start && io_dev != map_pkg::none)
				begin
					hi_pending <= !cpu_bhe_n_q;
					if (!cpu_a0)
					begin
						io_req <= ~io_req;
						state <= low_byte;
					end
					else if (!cpu_bhe_n_q)
					begin
						io_req <= ~io_req;
						state <= high_byte;
					end
				end
			end
			low_byte:
			begin
				if (acked && hi_pending)
				begin
					io_req <= ~io_req;
					state <= high_byte;
				end
				else if (acked)
					state <= idle;
			end
			high_byte:
			begin
				if (acked)
					state <= idle;
			end
			default:
				state <= idle;
		endcase
	end
end

//////////////////////////////////////////////////////////////////////
// Request payload and read assembly
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
	if (start_ok)
	begin
		io_dev_sel <= io_dev;
		io_req_write <= io_write;
		io_addr <= io_port;
		hi_byte <= io_wword[15:8];
		// Odd port carries data on the upper lane
		io_wdata <= cpu_a0 ? io_wword[15:8] : io_wword[7:0];
		// Touched bytes of an unmapped port read as all ones
		if (io_dev == map_pkg::none && !cpu_a0)
			io_result[7:0] <= 8'hFF;
		if (io_dev == map_pkg::none && !cpu_bhe_n_q)
			io_result[15:8] <= 8'hFF;
	end
	if (state == low_byte && acked)
	begin
		if (!io_req_write)
			io_result[7:0] <= io_rdata;
		// Second byte at port plus one
		if (hi_pending)
		begin
			io_addr[0] <= 1'b1;
			io_wdata <= hi_byte;
		end
	end
	if (state == high_byte && acked && !io_req_write)
		io_result[15:8] <= io_rdata;
end

endmodule

// ==== map_pkg.sv ====
package map_pkg;

// Memory region behind the toggle handshake
typedef enum logic [1:0] {
	bios,
	vram,
	ram
} region_e;

// 8-bit I/O devices, none for an unmapped port
typedef enum logic [3:0] {
	none,
	spi,
	pit,
	pic,
	vga,
	dbg,
	ps2,
	opl,
	com1
} dev_e;

//////////////////////////////////////////////////////////////////////
// Memory windows, compare width counts upper address bits
//////////////////////////////////////////////////////////////////////

localparam bus_pkg::addr_t bios_lo_base = 24'h0F0000;
localparam bus_pkg::addr_t bios_hi_base = 24'hFF0000;
localparam int bios_cmp_w = 8;
localparam bus_pkg::addr_t vram_base = 24'h0A0000;
localparam int vram_cmp_w = 7;

//////////////////////////////////////////////////////////////////////
// I/O windows, compare width counts upper port bits
//////////////////////////////////////////////////////////////////////

localparam logic [bus_pkg::port_w-1:0] spi_base = 12'h0B0;
localparam int spi_cmp_w = 10;
localparam logic [bus_pkg::port_w-1:0] pit_base = 12'h040;
localparam int pit_cmp_w = 10;
localparam logic [bus_pkg::port_w-1:0] pic_base = 12'h020;
localparam int pic_cmp_w = 11;
// VGA spans two 32-port blocks plus one stray port
localparam logic [bus_pkg::port_w-1:0] vga_lo_base = 12'h3A0;
localparam logic [bus_pkg::port_w-1:0] vga_hi_base = 12'h3C0;
localparam int vga_cmp_w = 7;
localparam logic [bus_pkg::port_w-1:0] vga_alt_base = 12'h0BE;
localparam int vga_alt_cmp_w = 12;
// Debug port, write only
localparam logic [bus_pkg::port_w-1:0] dbg_base = 12'h0BC;
localparam int dbg_cmp_w = 12;
localparam logic [bus_pkg::port_w-1:0] ps2_base = 12'h060;
localparam int ps2_cmp_w = 9;
localparam logic [bus_pkg::port_w-1:0] opl_base = 12'h388;
localparam int opl_cmp_w = 9;
localparam logic [bus_pkg::port_w-1:0] com1_base = 12'h3F8;
localparam int com1_cmp_w = 9;

// Window match on the upper cmp_w address bits
function automatic logic mem_hit(input bus_pkg::addr_t addr, input bus_pkg::addr_t base,
	input int cmp_w);
	return (addr >> (bus_pkg::addr_w - cmp_w)) == (base >> (bus_pkg::addr_w - cmp_w));
endfunction

// Same match on a port number
function automatic logic io_hit(input logic [bus_pkg::port_w-1:0] port,
	input logic [bus_pkg::port_w-1:0] base, input int cmp_w);
	return (port >> (bus_pkg::port_w - cmp_w)) == (base >> (bus_pkg::port_w - cmp_w));
endfunction

endpackage

// ==== pc_bus_frontend.sv ====
module pc_bus_frontend #(
	parameter int cpu_clk_div = 2
) (
	input  logic                          clk,
	input  logic                          reset_n,
	// CPU bus
	input  bus_pkg::addr_t                cpu_a,
	input  logic                          cpu_bhe_n,
	input  logic                          cpu_s0_n,
	input  logic                          cpu_s1_n,
	input  logic                          cpu_mio,
	input  logic                          cpu_inta_n,
	input  bus_pkg::word_t                cpu_wdata,
	output logic                          cpu_clk_n,
	output logic                          cpu_ready,
	output bus_pkg::word_t                cpu_rdata,
	output logic                          cpu_rdata_en,
	input  bus_pkg::byte_t                irq_vector,
	// Memory side
	output logic                          mem_rd_req,
	output logic                          mem_wr_req,
	output map_pkg::region_e              mem_region,
	output bus_pkg::addr_t                mem_addr,
	output logic                          mem_bhe_n,
	output bus_pkg::word_t                mem_wdata,
	input  logic                          mem_ack,
	input  bus_pkg::word_t                mem_rdata,
	// I/O side
	output logic                          io_req,
	output logic                          io_req_write,
	output map_pkg::dev_e                 io_dev_sel,
	output logic [bus_pkg::port_w-1:0]    io_addr,
	output bus_pkg::byte_t                io_wdata,
	input  logic                          io_ack,
	input  bus_pkg::byte_t                io_rdata
);

logic phase_tick;
bus_pkg::cycle_e cycle;
logic mem_busy;
// Decode to bridge
logic io_start;
logic io_write;
map_pkg::dev_e io_dev;
logic [bus_pkg::port_w-1:0] io_port;
logic cpu_a0;
logic cpu_bhe_n_q;
bus_pkg::word_t io_wword;
// Bridge to read path
logic io_busy;
bus_pkg::word_t io_result;

bus_decode #(
	.cpu_clk_div(cpu_clk_div)
) bus_decode_i (
	.clk(clk),
	.reset_n(reset_n),
	.cpu_a(cpu_a),
	.cpu_bhe_n(cpu_bhe_n),
	.cpu_s0_n(cpu_s0_n),
	.cpu_s1_n(cpu_s1_n),
	.cpu_mio(cpu_mio),
	.cpu_inta_n(cpu_inta_n),
	.cpu_wdata(cpu_wdata),
	.cpu_clk_n(cpu_clk_n),
	.phase_tick(phase_tick),
	.cycle(cycle),
	.mem_rd_req(mem_rd_req),
	.mem_wr_req(mem_wr_req),
	.mem_region(mem_region),
	.mem_addr(mem_addr),
	.mem_bhe_n(mem_bhe_n),
	.mem_wdata(mem_wdata),
	.mem_ack(mem_ack),
	.mem_busy(mem_busy),
	.io_start(io_start),
	.io_write(io_write),
	.io_dev(io_dev),
	.io_port(io_port),
	.cpu_a0(cpu_a0),
	.cpu_bhe_n_q(cpu_bhe_n_q),
	.io_wword(io_wword)
);

io_bridge io_bridge_i (
	.clk(clk),
	.reset_n(reset_n),
	.io_start(io_start),
	.io_write(io_write),
	.io_dev(io_dev),
	.io_port(io_port),
	.cpu_a0(cpu_a0),
	.cpu_bhe_n_q(cpu_bhe_n_q),
	.io_wword(io_wword),
	.io_req(io_req),
	.io_req_write(io_req_write),
	.io_dev_sel(io_dev_sel),
	.io_addr(io_addr),
	.io_wdata(io_wdata),
	.io_ack(io_ack),
	.io_rdata(io_rdata),
	.io_busy(io_busy),
	.io_result(io_result)
);

read_return read_return_i (
	.clk(clk),
	.reset_n(reset_n),
	.phase_tick(phase_tick),
	.cycle(cycle),
	.mem_busy(mem_busy),
	.io_busy(io_busy),
	.mem_rdata(mem_rdata),
	.io_result(io_result),
	.irq_vector(irq_vector),
	.cpu_ready(cpu_ready),
	.cpu_rdata(cpu_rdata),
	.cpu_rdata_en(cpu_rdata_en)
);

endmodule

// ==== read_return.sv ====
module read_return (
	input  logic            clk,
	input  logic            reset_n,
	input  logic            phase_tick,
	input  bus_pkg::cycle_e cycle,
	input  logic            mem_busy,
	input  logic            io_busy,
	input  bus_pkg::word_t  mem_rdata,
	input  bus_pkg::word_t  io_result,
	input  bus_pkg::byte_t  irq_vector,
	output logic            cpu_ready,
	output bus_pkg::word_t  cpu_rdata,
	output logic            cpu_rdata_en
);

logic idle_now;
logic read_cycle;

// Both handshakes settled, io_busy also spans the start pulse
assign idle_now = !mem_busy && !io_busy;

assign read_cycle = cycle == bus_pkg::mem_read || cycle == bus_pkg::io_read ||
	cycle == bus_pkg::inta;

//////////////////////////////////////////////////////////////////////
// Ready and bus drive
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge reset_n)
begin
	if (!reset_n)
	begin
		cpu_ready <= 1'b0;
		cpu_rdata_en <= 1'b0;
	end
	else
	begin
		// Drive the data bus only while the CPU expects to read
		cpu_rdata_en <= read_cycle;
		// Low the tick after T2, high again the tick after the last ack
		if (phase_tick)
			cpu_ready <= idle_now;
	end
end

//////////////////////////////////////////////////////////////////////
// Read word
//////////////////////////////////////////////////////////////////////

// Loaded together with ready, so data and ready change on one tick
always_ff @(posedge clk)
begin
	if (phase_tick && idle_now)
	begin
		case (cycle)
			bus_pkg::mem_read:
				cpu_rdata <= mem_rdata;
			bus_pkg::io_read:
				cpu_rdata <= io_result;
			// Vector on the low lane
			bus_pkg::inta:
				cpu_rdata <= {8'h00, irq_vector};
			default:
				cpu_rdata <= cpu_rdata;
		endcase
	end
end

endmodule

// ==== tb_pc_bus_frontend.sv ====
module tb_pc_bus_frontend;

localparam int clk_period = 40;
localparam int drive_dly = 2;
// Bus cycles per test
localparam int n_mem = 40;
localparam int n_io = 60;
localparam int n_unmapped = 12;
localparam int n_inta = 8;
localparam int n_mixed = 40;
localparam int total_cycles = n_mem + n_io + n_unmapped + n_inta + n_mixed;
// Slowest cycle in clk: two phases, two late byte acks, ready lag
localparam int cycle_clks = 48;
localparam int time_limit = (8 + total_cycles * cycle_clks) * clk_period;
// Cycle kinds
localparam int k_mem_read = 0;
localparam int k_mem_write = 1;
localparam int k_io_read = 2;
localparam int k_io_write = 3;
localparam int k_inta = 4;

logic clk = 1'b0;
logic reset_n;
bus_pkg::addr_t cpu_a;
logic cpu_bhe_n;
logic cpu_s0_n;
logic cpu_s1_n;
logic cpu_mio;
logic cpu_inta_n;
bus_pkg::word_t cpu_wdata;
logic cpu_clk_n;
logic cpu_ready;
bus_pkg::word_t cpu_rdata;
logic cpu_rdata_en;
bus_pkg::byte_t irq_vector;
logic mem_rd_req;
logic mem_wr_req;
map_pkg::region_e mem_region;
bus_pkg::addr_t mem_addr;
logic mem_bhe_n;
bus_pkg::word_t mem_wdata;
logic mem_ack;
bus_pkg::word_t mem_rdata;
logic io_req;
logic io_req_write;
map_pkg::dev_e io_dev_sel;
logic [11:0] io_addr;
bus_pkg::byte_t io_wdata;
logic io_ack;
bus_pkg::byte_t io_rdata;

int errors = 0;
int checks = 0;
// Memory responder record
int mem_rd_count = 0;
int mem_wr_count = 0;
map_pkg::region_e last_region;
bus_pkg::addr_t last_addr;
logic last_bhe_n;
bus_pkg::word_t last_wdata;
// I/O responder log, one entry per byte request
map_pkg::dev_e log_dev[$];
logic [11:0] log_port[$];
logic log_write[$];
bus_pkg::byte_t log_wdata[$];

pc_bus_frontend #(
	.cpu_clk_div(2)
) pc_bus_frontend_i (
	.clk(clk),
	.reset_n(reset_n),
	.cpu_a(cpu_a),
	.cpu_bhe_n(cpu_bhe_n),
	.cpu_s0_n(cpu_s0_n),
	.cpu_s1_n(cpu_s1_n),
	.cpu_mio(cpu_mio),
	.cpu_inta_n(cpu_inta_n),
	.cpu_wdata(cpu_wdata),
	.cpu_clk_n(cpu_clk_n),
	.cpu_ready(cpu_ready),
	.cpu_rdata(cpu_rdata),
	.cpu_rdata_en(cpu_rdata_en),
	.irq_vector(irq_vector),
	.mem_rd_req(mem_rd_req),
	.mem_wr_req(mem_wr_req),
	.mem_region(mem_region),
	.mem_addr(mem_addr),
	.mem_bhe_n(mem_bhe_n),
	.mem_wdata(mem_wdata),
	.mem_ack(mem_ack),
	.mem_rdata(mem_rdata),
	.io_req(io_req),
	.io_req_write(io_req_write),
	.io_dev_sel(io_dev_sel),
	.io_addr(io_addr),
	.io_wdata(io_wdata),
	.io_ack(io_ack),
	.io_rdata(io_rdata)
);

always #(clk_period / 2) clk = ~clk;

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Memory contents, every address bit matters
function automatic bus_pkg::word_t mem_word(input bus_pkg::addr_t a);
	return {a[7:0] ^ a[23:16], 8'(a[15:8] + 8'h5A)};
endfunction

// Device register contents, neighbouring ports differ
function automatic bus_pkg::byte_t port_byte(input logic [11:0] port);
	return 8'(port[7:0] + 8'h3C) ^ {port[3:0], port[11:8]};
endfunction

function automatic map_pkg::region_e region_of(input bus_pkg::addr_t a, input logic is_read);
	// BIOS shadows only on reads
	if (is_read && ((a >= 24'h0F0000 && a <= 24'h0FFFFF) || a >= 24'hFF0000))
		return map_pkg::bios;
	if (a >= 24'h0A0000 && a <= 24'h0BFFFF)
		return map_pkg::vram;
	return map_pkg::ram;
endfunction

function automatic map_pkg::dev_e dev_of(input logic [11:0] p, input logic is_write);
	if (p >= 12'h0B0 && p <= 12'h0B3)
		return map_pkg::spi;
	if (p >= 12'h040 && p <= 12'h043)
		return map_pkg::pit;
	if (p >= 12'h020 && p <= 12'h021)
		return map_pkg::pic;
	if ((p >= 12'h3A0 && p <= 12'h3DF) || p == 12'h0BE)
		return map_pkg::vga;
	if (p == 12'h0BC && is_write)
		return map_pkg::dbg;
	if (p >= 12'h060 && p <= 12'h067)
		return map_pkg::ps2;
	if (p >= 12'h388 && p <= 12'h38F)
		return map_pkg::opl;
	if (p >= 12'h3F8 && p <= 12'h3FF)
		return map_pkg::com1;
	return map_pkg::none;
endfunction

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

task automatic check_equal(input string sig, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp)
	else
	begin
		$display("Error at %0t: %s is %h, expected %h", $time, sig, got, exp);
		errors++;
	end
endtask

task automatic check_true(input logic cond, input string what);
	checks++;
	assert (cond)
	else
	begin
		$display("At %0t: %s", $time, what);
		errors++;
	end
endtask

//////////////////////////////////////////////////////////////////////
// Responders
//////////////////////////////////////////////////////////////////////

// Memory side, random ack latency
initial
begin
	int delay;
	logic prev_rd;
	logic prev_wr;
	mem_ack = 1'b0;
	mem_rdata = '0;
	prev_rd = 1'b0;
	prev_wr = 1'b0;
	forever
	begin
		@(posedge clk);
		#drive_dly;
		if ((mem_rd_req ^ mem_wr_req) != mem_ack)
		begin
			if (mem_rd_req != prev_rd)
				mem_rd_count++;
			if (mem_wr_req != prev_wr)
				mem_wr_count++;
			prev_rd = mem_rd_req;
			prev_wr = mem_wr_req;
			last_region = mem_region;
			last_addr = mem_addr;
			last_bhe_n = mem_bhe_n;
			last_wdata = mem_wdata;
			delay = int'($urandom % 7);
			repeat (delay) @(posedge clk);
			#drive_dly;
			mem_rdata = mem_word(mem_addr);
			mem_ack = ~mem_ack;
		end
	end
end

// I/O side logs each byte request
initial
begin
	int delay;
	io_ack = 1'b0;
	io_rdata = '0;
	forever
	begin
		@(posedge clk);
		#drive_dly;
		if (io_req != io_ack)
		begin
			log_dev.push_back(io_dev_sel);
			log_port.push_back(io_addr);
			log_write.push_back(io_req_write);
			log_wdata.push_back(io_wdata);
			delay = int'($urandom % 7);
			repeat (delay) @(posedge clk);
			#drive_dly;
			io_rdata = port_byte(io_addr);
			io_ack = ~io_ack;
		end
	end
end

//////////////////////////////////////////////////////////////////////
// CPU driver
//////////////////////////////////////////////////////////////////////

task automatic run_cycle(input int kind, input bus_pkg::addr_t addr, input logic bhe_n,
	input bus_pkg::word_t wdata, input bus_pkg::byte_t vec);
	int rd_before;
	int wr_before;
	int n_exp;
	logic is_read;
	logic [11:0] port;
	map_pkg::dev_e dev;
	logic [11:0] exp_port[2];
	bus_pkg::byte_t exp_byte[2];
	bus_pkg::word_t exp_word;
	bus_pkg::word_t mask;
	rd_before = mem_rd_count;
	wr_before = mem_wr_count;
	log_dev.delete();
	log_port.delete();
	log_write.delete();
	log_wdata.delete();
	// T1 status and address
	@(negedge cpu_clk_n);
	#drive_dly;
	cpu_a = addr;
	cpu_bhe_n = bhe_n;
	cpu_wdata = wdata;
	irq_vector = vec;
	case (kind)
		k_mem_read:  {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1101;
		k_mem_write: {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1110;
		k_io_read:   {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1001;
		k_io_write:  {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b1010;
		default:     {cpu_inta_n, cpu_mio, cpu_s1_n, cpu_s0_n} = 4'b0000;
	endcase
	// T2 passive status, data held
	@(negedge cpu_clk_n);
	#drive_dly;
	{cpu_inta_n, cpu_s1_n, cpu_s0_n} = 3'b111;
	// Ready written on the T2 tick is stale
	@(posedge cpu_clk_n);
	@(posedge cpu_clk_n);
	while (!cpu_ready)
		@(posedge cpu_clk_n);
	check_true(mem_ack == (mem_rd_req ^ mem_wr_req) && io_ack == io_req,
		"cpu_ready went high while a request was still open");

	// Memory request count and payload
	is_read = kind == k_mem_read || kind == k_io_read || kind == k_inta;
	check_equal("mem read requests", 32'(mem_rd_count - rd_before), 32'(kind == k_mem_read));
	check_equal("mem write requests", 32'(mem_wr_count - wr_before), 32'(kind == k_mem_write));
	if (kind == k_mem_read || kind == k_mem_write)
	begin
		check_equal("mem_region", 32'(last_region), 32'(region_of(addr, is_read)));
		check_equal("mem_addr", 32'(last_addr), 32'(addr));
		check_equal("mem_bhe_n", 32'(last_bhe_n), 32'(bhe_n));
		if (kind == k_mem_write)
			check_equal("mem_wdata", 32'(last_wdata), 32'(wdata));
	end

	// Expected byte sequence, low lane first
	port = addr[11:0];
	dev = dev_of(port, kind == k_io_write);
	n_exp = 0;
	if ((kind == k_io_read || kind == k_io_write) && dev != map_pkg::none)
	begin
		if (!addr[0])
		begin
			exp_port[n_exp] = port;
			exp_byte[n_exp] = wdata[7:0];
			n_exp++;
		end
		if (!bhe_n)
		begin
			exp_port[n_exp] = port | 12'h001;
			exp_byte[n_exp] = wdata[15:8];
			n_exp++;
		end
	end
	check_equal("io byte requests", 32'(log_port.size()), 32'(n_exp));
	for (int i = 0; i < n_exp && i < log_port.size(); i++)
	begin
		check_equal("io_dev_sel", 32'(log_dev[i]), 32'(dev));
		check_equal("io_addr", 32'(log_port[i]), 32'(exp_port[i]));
		check_equal("io_req_write", 32'(log_write[i]), 32'(kind == k_io_write));
		if (kind == k_io_write)
			check_equal("io_wdata", 32'(log_wdata[i]), 32'(exp_byte[i]));
	end

	// Read word, only the lanes the CPU asked for
	exp_word = '0;
	mask = 16'hFFFF;
	if (kind == k_mem_read)
		exp_word = mem_word(addr);
	else if (kind == k_inta)
		exp_word = {8'h00, vec};
	else if (kind == k_io_read)
	begin
		mask = '0;
		if (!addr[0])
		begin
			mask[7:0] = 8'hFF;
			exp_word[7:0] = (dev == map_pkg::none) ? 8'hFF : port_byte(port);
		end
		if (!bhe_n)
		begin
			mask[15:8] = 8'hFF;
			exp_word[15:8] = (dev == map_pkg::none) ? 8'hFF : port_byte(port | 12'h001);
		end
	end
	if (is_read)
		check_equal("cpu_rdata", 32'(cpu_rdata & mask), 32'(exp_word & mask));
	check_equal("cpu_rdata_en", 32'(cpu_rdata_en), 32'(is_read));
endtask

//////////////////////////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////////////////////////

// Mode 0 memory, 1 mapped I/O, 2 unmapped I/O, 3 inta, 4 any of these
task automatic run_random(input string name, input int mode, input int count);
	int errs_before;
	int m;
	int kind;
	int entry;
	bus_pkg::addr_t addr;
	logic bhe_n;
	logic [11:0] port;
	logic [11:0] port_base[11];
	int port_span[11];
	// Mapped windows first, then two unmapped ones
	port_base = '{12'h0B0, 12'h040, 12'h020, 12'h3A0, 12'h0BE, 12'h0BC, 12'h060,
		12'h388, 12'h3F8, 12'h200, 12'h2F8};
	port_span = '{4, 4, 2, 64, 1, 1, 8, 8, 8, 16, 8};
	errs_before = errors;
	for (int n = 0; n < count; n++)
	begin
		m = (mode == 4) ? int'($urandom % 4) : mode;
		bhe_n = 1'($urandom);
		if (m == 0)
		begin
			kind = int'($urandom % 2);
			case ($urandom % 4)
				0: addr = 24'h0F0000 | 24'($urandom % 32'h10000);
				1: addr = 24'hFF0000 | 24'($urandom % 32'h10000);
				2: addr = 24'h0A0000 + 24'($urandom % 32'h20000);
				default: addr = 24'($urandom);
			endcase
		end
		else if (m == 3)
		begin
			kind = k_inta;
			addr = '0;
		end
		else
		begin
			kind = ($urandom % 2 == 0) ? k_io_read : k_io_write;
			entry = (m == 1) ? int'($urandom % 9) : 9 + int'($urandom % 2);
			port = port_base[entry] + 12'($urandom % 32'(port_span[entry]));
			// Odd port is a high byte, even port a low byte or a word
			if (port[0])
				bhe_n = 1'b0;
			else
				bhe_n = ($urandom % 3 == 0);
			addr = {12'h000, port};
		end
		run_cycle(kind, addr, bhe_n, 16'($urandom), 8'($urandom));
	end
	$display("test %s: %0d cycles, %0d errors", name, count, errors - errs_before);
endtask

// Watchdog
initial
begin
	#(time_limit);
	$display("Timeout: the bus cycles did not complete in the expected time");
	$display("Simulation failed");
	$finish;
end

initial
begin
	void'($urandom(19));
	reset_n = 1'b0;
	cpu_a = '0;
	cpu_bhe_n = 1'b1;
	cpu_s0_n = 1'b1;
	cpu_s1_n = 1'b1;
	cpu_mio = 1'b1;
	cpu_inta_n = 1'b1;
	cpu_wdata = '0;
	irq_vector = '0;
	repeat (8) @(posedge clk);
	#drive_dly;
	check_equal("cpu_ready", 32'(cpu_ready), 32'(0));
	check_equal("cpu_rdata_en", 32'(cpu_rdata_en), 32'(0));
	check_equal("cpu_clk_n", 32'(cpu_clk_n), 32'(0));
	check_equal("mem_rd_req", 32'(mem_rd_req), 32'(0));
	check_equal("mem_wr_req", 32'(mem_wr_req), 32'(0));
	check_equal("io_req", 32'(io_req), 32'(0));
	check_equal("io_busy", 32'(pc_bus_frontend_i.io_busy), 32'(0));
	$display("test reset: %0d errors", errors);
	reset_n = 1'b1;
	run_random("memory", 0, n_mem);
	run_random("io_mapped", 1, n_io);
	run_random("io_unmapped", 2, n_unmapped);
	run_random("inta", 3, n_inta);
	run_random("mixed", 4, n_mixed);
	$display("checks: %0d run, %0d errors", checks, errors);
	if (errors == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule
